// File: hw/cpuPkg.sv
/*
 * Shared types for the pipelined RV32I subset core:
 * word and register index types, opcode, ALU control,
 * result source, immediate format and forwarding select enums.
 */
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;     // data word or address
    typedef logic [4:0]  regAddrT;  // register index

    // major opcodes kept by the core
    typedef enum logic [6:0] {
        opLoad  = 7'b0000011,
        opStore = 7'b0100011,
        opReg   = 7'b0110011,
        opImm   = 7'b0010011
    } opcodeT;

    // ALU operations
    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlT;

    // writeback value select
    typedef enum logic {
        resAlu = 1'b0,
        resMem = 1'b1   // load data
    } resultSrcT;

    // immediate format
    typedef enum logic {
        immI = 1'b0,
        immS = 1'b1
    } immSrcT;

    // execute operand source
    typedef enum logic [1:0] {
        fwdNone = 2'b00,  // register file value
        fwdWb   = 2'b01,  // writeback result
        fwdMem  = 2'b10   // memory stage ALU result
    } fwdSelT;

endpackage : cpuPkg

`default_nettype wire

// File: hw/instrDecoder.sv
/*
 * Decode stage logic: main decoder, ALU decoder and
 * I/S immediate sign extension. Unknown opcodes become no-ops.
 */
`default_nettype none

module instrDecoder
    import cpuPkg::*;
(
    input  wordT      instr,
    output logic      regWrite,
    output logic      memWrite,
    output resultSrcT resultSrc,
    output aluCtrlT   aluCtrl,
    output logic      aluSrc,
    output wordT      imm,
    output regAddrT   rs1,
    output regAddrT   rs2,
    output regAddrT   rd
);

    opcodeT opcode;
    immSrcT immSrc;
    logic   useFunct;   // ALU op taken from funct3/funct7
    wordT   immIType;
    wordT   immSType;

    assign opcode = opcodeT'(instr[6:0]);

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // main decoder
    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        resultSrc = resAlu;
        aluSrc    = 1'b0;
        immSrc    = immI;
        useFunct  = 1'b0;
        case (opcode)
            opLoad: begin
                regWrite  = 1'b1;
                resultSrc = resMem;
                aluSrc    = 1'b1;
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opReg: begin
                regWrite = 1'b1;
                useFunct = 1'b1;
            end
            opImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                useFunct = 1'b1;
            end
            default: ;  // no-op, nothing written
        endcase
    end

    // ALU decoder, address calc otherwise
    always_comb begin
        aluCtrl = aluAdd;
        if (useFunct) begin
            case (instr[14:12])
                3'b000: if (opcode == opReg && instr[30]) aluCtrl = aluSub;
                3'b010: aluCtrl = aluSlt;
                3'b110: aluCtrl = aluOr;
                3'b111: aluCtrl = aluAnd;
                default: aluCtrl = aluAdd;
            endcase
        end
    end

    assign immIType = {{20{instr[31]}}, instr[31:20]};
    assign immSType = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm      = (immSrc == immS) ? immSType : immIType;

endmodule : instrDecoder

`default_nettype wire

// File: hw/registerFile.sv
/*
 * 32 x 32-bit register file, x0 hard wired to zero,
 * rising edge write with bypass to both read ports.
 */
`default_nettype none

module registerFile
    import cpuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    writeEn,
    input  regAddrT readAddrA,
    input  regAddrT readAddrB,
    input  regAddrT writeAddr,
    input  wordT    writeData,
    output wordT    readDataA,
    output wordT    readDataB
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write seen by decode
    assign readDataA = (readAddrA == '0) ? '0 :
                       (writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 :
                       (writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule : registerFile

`default_nettype wire

// File: hw/alu.sv
/*
 * 32-bit ALU: add, sub, and, or, signed set-less-than
 */
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  aluCtrlT aluCtrl,
    input  wordT    srcA,
    input  wordT    srcB,
    output wordT    y
);

    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluCtrl)
            aluAdd:  y = srcA + srcB;
            aluSub:  y = srcA - srcB;  // wraps
            aluAnd:  y = srcA & srcB;
            aluOr:   y = srcA | srcB;
            aluSlt:  y = {31'b0, lessThan};
            default: y = srcA + srcB;
        endcase
    end

endmodule : alu

`default_nettype wire

// File: hw/hazardUnit.sv
/*
 * Hazard unit: forwarding selects for the execute operands
 * and the one-cycle load-use stall.
 */
`default_nettype none

module hazardUnit
    import cpuPkg::*;
(
    input  regAddrT rs1Dec,
    input  regAddrT rs2Dec,
    input  regAddrT rs1Ex,
    input  regAddrT rs2Ex,
    input  regAddrT rdEx,
    input  regAddrT rdMem,
    input  regAddrT rdWb,
    input  logic    loadEx,
    input  logic    regWriteMem,
    input  logic    regWriteWb,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB,
    output logic    stall
);

    // memory stage wins over writeback, x0 never forwarded
    function automatic fwdSelT pickFwd(input regAddrT rs);
        fwdSelT sel;
        sel = fwdNone;
        if (rs != '0) begin
            if (regWriteMem && rs == rdMem) sel = fwdMem;
            else if (regWriteWb && rs == rdWb) sel = fwdWb;
        end
        return sel;
    endfunction

    assign fwdA = pickFwd(rs1Ex);
    assign fwdB = pickFwd(rs2Ex);

    // load result not ready until writeback
    assign stall = loadEx && (rdEx != '0) && (rdEx == rs1Dec || rdEx == rs2Dec);

endmodule : hazardUnit

`default_nettype wire

// File: hw/cpu.sv
/*
 * Five-stage pipelined RV32I subset core (lw, sw, add, sub, and,
 * or, slt, addi, andi, ori, slti). PC, pipeline registers,
 * operand forwarding and result muxes; memories are external.
 */
`default_nettype none

module cpu
    import cpuPkg::*;
#(
    parameter wordT resetPc = 32'h00400000
) (
    input  logic clk,
    input  logic rst,
    input  wordT instr,
    input  wordT readData,
    output wordT pc,
    output wordT aluResult,
    output wordT writeData,
    output logic memWrite,
    output wordT result
);

    // fetch
    wordT pcF;
    logic stall;

    // decode
    wordT      instrD;
    logic      regWriteD;
    logic      memWriteD;
    resultSrcT resultSrcD;
    aluCtrlT   aluCtrlD;
    logic      aluSrcD;
    wordT      immD;
    regAddrT   rs1D;
    regAddrT   rs2D;
    regAddrT   rdD;
    wordT      rd1D;
    wordT      rd2D;

    // execute
    logic      regWriteE;
    logic      memWriteE;
    resultSrcT resultSrcE;
    aluCtrlT   aluCtrlE;
    logic      aluSrcE;
    wordT      rd1E;
    wordT      rd2E;
    wordT      immE;
    regAddrT   rs1E;
    regAddrT   rs2E;
    regAddrT   rdE;
    fwdSelT    fwdA;
    fwdSelT    fwdB;
    wordT      srcAE;
    wordT      srcBE;
    wordT      writeDataE;
    wordT      aluResultE;

    // memory
    logic      regWriteM;
    logic      memWriteM;
    resultSrcT resultSrcM;
    wordT      aluResultM;
    wordT      writeDataM;
    regAddrT   rdM;

    // writeback
    logic      regWriteW;
    resultSrcT resultSrcW;
    wordT      aluResultW;
    wordT      readDataW;
    regAddrT   rdW;
    wordT      resultW;

    function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal);
        wordT val;
        case (sel)
            fwdWb:   val = resultW;
            fwdMem:  val = aluResultM;
            default: val = regVal;
        endcase
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= resetPc;
        end else if (!stall) begin
            pcF <= pcF + 32'd4;
        end
    end

    assign pc = pcF;

    // decode register, held on load-use
    always_ff @(posedge clk) begin
        if (rst) begin
            instrD <= '0;  // decodes as no-op
        end else if (!stall) begin
            instrD <= instr;
        end
    end

    instrDecoder i_instrDecoder (
        .instr     (instrD),
        .regWrite  (regWriteD),
        .memWrite  (memWriteD),
        .resultSrc (resultSrcD),
        .aluCtrl   (aluCtrlD),
        .aluSrc    (aluSrcD),
        .imm       (immD),
        .rs1       (rs1D),
        .rs2       (rs2D),
        .rd        (rdD)
    );

    registerFile i_registerFile (
        .clk       (clk),
        .rst       (rst),
        .writeEn   (regWriteW),
        .readAddrA (rs1D),
        .readAddrB (rs2D),
        .writeAddr (rdW),
        .writeData (resultW),
        .readDataA (rd1D),
        .readDataB (rd2D)
    );

    // execute register, bubble on stall
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSrcE <= resAlu;
            aluCtrlE   <= aluAdd;
            aluSrcE    <= 1'b0;
            rd1E       <= '0;
            rd2E       <= '0;
            immE       <= '0;
            rs1E       <= '0;
            rs2E       <= '0;
            rdE        <= '0;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSrcE <= resultSrcD;
            aluCtrlE   <= aluCtrlD;
            aluSrcE    <= aluSrcD;
            rd1E       <= rd1D;
            rd2E       <= rd2D;
            immE       <= immD;
            rs1E       <= rs1D;
            rs2E       <= rs2D;
            rdE        <= rdD;
        end
    end

    hazardUnit i_hazardUnit (
        .rs1Dec      (rs1D),
        .rs2Dec      (rs2D),
        .rs1Ex       (rs1E),
        .rs2Ex       (rs2E),
        .rdEx        (rdE),
        .rdMem       (rdM),
        .rdWb        (rdW),
        .loadEx      (resultSrcE == resMem),
        .regWriteMem (regWriteM),
        .regWriteWb  (regWriteW),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall)
    );

    assign srcAE      = fwdMux(fwdA, rd1E);
    assign writeDataE = fwdMux(fwdB, rd2E);  // also store data
    assign srcBE      = aluSrcE ? immE : writeDataE;

    alu i_alu (
        .aluCtrl (aluCtrlE),
        .srcA    (srcAE),
        .srcB    (srcBE),
        .y       (aluResultE)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= resAlu;
            aluResultM <= '0;
            writeDataM <= '0;
            rdM        <= '0;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            rdM        <= rdE;
        end
    end

    assign aluResult = aluResultM;
    assign writeData = writeDataM;
    assign memWrite  = memWriteM;

    always_ff @(posedge clk) begin
        if (rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= resAlu;
            aluResultW <= '0;
            readDataW  <= '0;
            rdW        <= '0;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
            aluResultW <= aluResultM;
            readDataW  <= readData;
            rdW        <= rdM;
        end
    end

    assign resultW = (resultSrcW == resMem) ? readDataW : aluResultW;
    assign result  = resultW;

endmodule : cpu

`default_nettype wire

// File: test/tbCpu.sv
/*
 * Testbench for the pipelined core with clock and reset, instruction
 * and data memory models, pattern file loading, store stream
 * checks and the final report.
 */
`default_nettype none

module tbCpu
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam wordT resetPc   = 32'h00400000;
    localparam wordT nopWord   = 32'h00000013;  // addi x0, x0, 0
    localparam int   maxWait   = 2000;
    localparam int   progDepth = 64;
    localparam int   dataDepth = 256;
    localparam int   numTests  = 6;

    logic clk = 1'b0;
    logic rst;
    wordT instr;
    wordT readData;
    wordT pc;
    wordT aluResult;
    wordT writeData;
    logic memWrite;
    wordT result;

    wordT progMem [progDepth];
    wordT dataMem [dataDepth];
    int   progLen;
    wordT expAddr [$];
    wordT expData [$];
    wordT gotAddr [$];
    wordT gotData [$];
    int   testErrors [numTests];
    int   curTest;

    cpu #(
        .resetPc (resetPc)
    ) i_cpu (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData),
        .memWrite  (memWrite),
        .result    (result)
    );

    always #50 clk = ~clk;

    function automatic wordT fetchWord(input wordT addr);
        wordT offset;
        offset = (addr - resetPc) >> 2;
        if (offset < progLen) return progMem[offset];
        return nopWord;  // past the end of the program
    endfunction

    function automatic int testOf(input wordT addr);
        if (addr < 32'h200) return 1;
        if (addr < 32'h300) return 2;
        if (addr < 32'h380) return 3;
        return 4;
    endfunction

    function automatic string testName(input int t);
        case (t)
            0:       return "reset";
            1:       return "alu ops";
            2:       return "forwarding";
            3:       return "load-use";
            4:       return "x0 and no-ops";
            default: return "store stream";
        endcase
    endfunction

    task automatic checkValue(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            testErrors[curTest]++;
        end
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s: %0d error(s)", t, testName(t), testErrors[t]);
    endtask

    // one cycle with both memories served at the falling edge
    task automatic tick();
        @(negedge clk);
        if (memWrite === 1'b1) begin
            dataMem[aluResult[9:2]] = writeData;
            gotAddr.push_back(aluResult);
            gotData.push_back(writeData);
        end
        instr    = fetchWord(pc);
        readData = dataMem[aluResult[9:2]];
    endtask

    task automatic loadPatterns();
        int    fd;
        int    n;
        string tag;
        string rest;
        wordT  addr;
        wordT  word;
        progLen = 0;
        fd = $fopen("test/cpuPatterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open test/cpuPatterns.txt");
            testErrors[5]++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %s", tag);
            if (n != 1) break;
            if (tag == "I") begin
                n = $fscanf(fd, " %h", word);
                progMem[progLen] = word;
                progLen++;
            end else if (tag == "D") begin
                n = $fscanf(fd, " %h %h", addr, word);
                dataMem[addr[9:2]] = word;
            end else if (tag == "S") begin
                n = $fscanf(fd, " %h %h", addr, word);
                expAddr.push_back(addr);
                expData.push_back(word);
            end else begin
                n = $fgets(rest, fd);  // comment line
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int   cycles;
        int   passed;
        int   failed;
        wordT drainPc;
        rst      = 1'b1;
        instr    = nopWord;
        readData = '0;
        curTest  = 0;
        foreach (testErrors[i]) testErrors[i] = 0;
        foreach (progMem[i]) progMem[i] = nopWord;
        foreach (dataMem[i]) dataMem[i] = '0;
        loadPatterns();

        repeat (10) begin
            tick();
            checkValue("pc", pc, resetPc);
            checkValue("memWrite", {31'b0, memWrite}, '0);
            checkValue("result", result, '0);  // writeback register cleared
        end
        rst = 1'b0;
        tick();
        checkValue("memWrite", {31'b0, memWrite}, '0);
        tick();
        checkValue("memWrite", {31'b0, memWrite}, '0);
        checkValue("pc", pc, resetPc + 32'd8);  // two fetches past reset
        reportTest(0);

        cycles = 0;
        while (gotAddr.size() < expAddr.size() && cycles < maxWait) begin
            tick();
            cycles++;
        end
        if (gotAddr.size() < expAddr.size()) begin
            $display("ERROR: expected stores never arrived, %0d of %0d seen",
                     gotAddr.size(), expAddr.size());
            testErrors[5]++;
        end

        // let the trailing no-ops run through every stage
        drainPc = resetPc + 32'(4 * (progLen + 6));
        cycles  = 0;
        while (pc < drainPc && cycles < maxWait) begin
            tick();
            cycles++;
        end
        if (pc < drainPc) begin
            $display("ERROR: program never ran to its end, pc stuck at %h", pc);
            testErrors[5]++;
        end

        for (int t = 1; t <= 4; t++) begin
            curTest = t;
            for (int k = 0; k < expAddr.size(); k++) begin
                if (testOf(expAddr[k]) == t) begin
                    if (k < gotAddr.size()) begin
                        checkValue("aluResult", gotAddr[k], expAddr[k]);
                        checkValue("writeData", gotData[k], expData[k]);
                    end else begin
                        $display("ERROR: store %0d to address %h never happened",
                                 k, expAddr[k]);
                        testErrors[t]++;
                    end
                end
            end
            reportTest(t);
        end

        curTest = 5;
        checkValue("store count", gotAddr.size(), expAddr.size());
        reportTest(5);

        passed = 0;
        failed = 0;
        foreach (testErrors[i]) begin
            if (testErrors[i] == 0) passed++;
            else failed++;
        end
        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tbCpu

`default_nettype wire

// File: sources.f
hw/cpuPkg.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/cpu.sv
test/tbCpu.sv

// File: test/cpuPatterns.txt
# I word: program word in order from resetPc; D addr word: initial data memory
# S addr word: next expected store, address then data
I 06400093
I FF900113
I 6F000193
I 0FF00213
I 002082B3
I 10502023
S 00000100 0000005D
I 40208333
I 10602223
S 00000104 0000006B
I 0041F3B3
I 10702423
S 00000108 000000F0
I 0041E433
I 10802623
S 0000010C 000006FF
I 001124B3
I 10902823
S 00000110 00000001
I F3808513
I 10A02A23
S 00000114 FFFFFF9C
I 03C1F593
I 10B02C23
S 00000118 00000030
I 70026613
I 10C02E23
S 0000011C 000007FF
I FFA12693
I 12D02023
S 00000120 00000001
# forwarding chains
I 00B00893
I 01488913
I 411909B3
I 0138EA33
I 01298AB3
I 21502023
I 21502223
I 21502423
I 21402623
S 00000200 00000033
S 00000204 00000033
S 00000208 00000033
S 0000020C 0000001F
# load-use
D 00000300 12345678
I 11100B13
I 30002B83
I 016B8C33
I 31802223
I 30002C83
I 31902423
S 00000304 12345789
S 00000308 12345678
# x0 writes and a beq word
I 06300013
I 00108033
I 2A500D13
I 00108463
I 39A02023
I 38002223
S 00000380 000002A5
S 00000384 00000000
